//--- design/pic_pkg.sv
// Interrupt controller definitions

package pic_pkg;

   localparam int NUM_SOURCES = 32;                  // Source 0 reserved
   localparam int PRIO_BITS   = 4;
   localparam int ID_BITS     = 5;
   localparam int TREE_LEVELS = $clog2(NUM_SOURCES);  // Compare stages in the tree

   typedef logic [PRIO_BITS-1:0]   prio_t;
   typedef logic [ID_BITS-1:0]     src_id_t;
   typedef logic [NUM_SOURCES-1:0] src_vec_t;

   localparam prio_t MAX_PRIO = prio_t'(15);

   // Register map, low half of the base is zero
   localparam logic [31:0] PIC_BASE_ADDR    = 32'hF00C_0000;
   localparam logic [31:0] PRIORITY_OFFSET  = 32'h0000_0000;
   localparam logic [31:0] PENDING_OFFSET   = 32'h0000_1000;
   localparam logic [31:0] ENABLE_OFFSET    = 32'h0000_2000;
   localparam logic [31:0] CONFIG_OFFSET    = 32'h0000_3000;
   localparam logic [31:0] GW_CONFIG_OFFSET = 32'h0000_4000;
   localparam logic [31:0] GW_CLEAR_OFFSET  = 32'h0000_5000;

   typedef enum logic [2:0] {
      REG_NONE,
      REG_PRIORITY,
      REG_PENDING,     // Read only
      REG_ENABLE,
      REG_CONFIG,
      REG_GW_CONFIG,
      REG_GW_CLEAR     // Write only
   } region_t;

endpackage

//--- design/pic_access_if.sv
// Decoded register access

`timescale 1ns/1ps

interface pic_access_if import pic_pkg::*; ();

   logic        rd_stb;      // Single cycle, no back-pressure
   logic        wr_stb;
   region_t     rd_region;
   region_t     wr_region;
   src_id_t     rd_index;
   src_id_t     wr_index;
   logic [31:0] wr_data;
   logic        bypass;      // Read and write hit the same address

   modport decode (
      output rd_stb, wr_stb, rd_region, wr_region,
      output rd_index, wr_index, wr_data, bypass
   );

   modport regs (
      input rd_stb, wr_stb, rd_region, wr_region,
      input rd_index, wr_index, wr_data, bypass
   );

endinterface

//--- design/pic_cfg_if.sv
// Per-source configuration

`timescale 1ns/1ps

interface pic_cfg_if import pic_pkg::*; ();

   prio_t [NUM_SOURCES-1:0] src_prio;   // Stored priority per source
   src_vec_t                enable;
   src_vec_t                gw_polarity;  // 1 means active low
   src_vec_t                gw_type;      // 1 means latched edge
   src_vec_t                gw_clear;     // One cycle pulse
   logic                    reverse_order;

   modport regs (
      output src_prio, enable, gw_polarity, gw_type, gw_clear, reverse_order
   );

   modport sink (
      input src_prio, enable, gw_polarity, gw_type, gw_clear, reverse_order
   );

endinterface

//--- design/pic_access_decode.sv
// Register access decoder

`timescale 1ns/1ps

module pic_access_decode import pic_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  logic [31:0]      picm_rdaddr,
   input  logic [31:0]      picm_wraddr,
   input  logic [31:0]      picm_wr_data,
   input  logic             picm_wren,
   input  logic             picm_rden,
   pic_access_if.decode     acc
);

   logic        rden_q, wren_q;
   logic [31:0] rdaddr_q, wraddr_q, wr_data_q;

   // Priority, enable and gateway regions span 32 words, pending one group
   function automatic region_t decode_region(input logic [31:0] addr);
      region_t region;
      region = REG_NONE;
      if (addr[31:16] == PIC_BASE_ADDR[31:16]) begin
         if (addr[15:7] == PRIORITY_OFFSET[15:7])        region = REG_PRIORITY;
         else if (addr[15:6] == PENDING_OFFSET[15:6])    region = REG_PENDING;
         else if (addr[15:7] == ENABLE_OFFSET[15:7])     region = REG_ENABLE;
         else if (addr[15:2] == CONFIG_OFFSET[15:2])     region = REG_CONFIG;
         else if (addr[15:7] == GW_CONFIG_OFFSET[15:7])  region = REG_GW_CONFIG;
         else if (addr[15:7] == GW_CLEAR_OFFSET[15:7])   region = REG_GW_CLEAR;
      end
      return region;
   endfunction

   // Pending uses the group select, only group 0 exists
   function automatic src_id_t decode_index(input logic [31:0] addr, input region_t region);
      return (region == REG_PENDING) ? src_id_t'(addr[5:2]) : addr[6:2];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Request capture
   always_ff @(posedge clk) begin
      if (reset) begin
         rden_q <= 1'b0;
         wren_q <= 1'b0;
      end else begin
         rden_q <= picm_rden;
         wren_q <= picm_wren;
      end
   end

   always_ff @(posedge clk) begin
      if (picm_rden) rdaddr_q <= picm_rdaddr;
      if (picm_wren) begin
         wraddr_q  <= picm_wraddr;
         wr_data_q <= picm_wr_data;
      end
   end

   assign acc.rd_stb    = rden_q;
   assign acc.wr_stb    = wren_q;
   assign acc.rd_region = decode_region(rdaddr_q);
   assign acc.wr_region = decode_region(wraddr_q);
   assign acc.rd_index  = decode_index(rdaddr_q, acc.rd_region);
   assign acc.wr_index  = decode_index(wraddr_q, acc.wr_region);
   assign acc.wr_data   = wr_data_q;
   assign acc.bypass    = rden_q & wren_q & (rdaddr_q == wraddr_q);  // Same word in flight

endmodule

//--- design/pic_reg_file.sv
// Configuration register file

`timescale 1ns/1ps

module pic_reg_file import pic_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   pic_access_if.regs    acc,
   input  src_vec_t      pending,       // Gateway outputs
   output logic [31:0]   picm_rd_data,
   pic_cfg_if.regs       cfg
);

   prio_t [NUM_SOURCES-1:0] prio_q;
   src_vec_t                enable_q;
   src_vec_t                polarity_q;
   src_vec_t                type_q;
   logic                    reverse_q;
   logic                    wr_src;        // Write to a real source
   logic [31:0]             rd_data;

   assign wr_src = acc.wr_stb & (acc.wr_index != '0);

   ////////////////////////////////////////////////////////////////////////////
   // Register writes, source 0 never written
   always_ff @(posedge clk) begin
      if (reset) begin
         prio_q     <= '0;
         enable_q   <= '0;
         polarity_q <= '0;
         type_q     <= '0;
         reverse_q  <= 1'b0;
      end else begin
         if (wr_src && acc.wr_region == REG_PRIORITY)
            prio_q[acc.wr_index] <= acc.wr_data[PRIO_BITS-1:0];
         if (wr_src && acc.wr_region == REG_ENABLE)
            enable_q[acc.wr_index] <= acc.wr_data[0];
         if (wr_src && acc.wr_region == REG_GW_CONFIG) begin
            polarity_q[acc.wr_index] <= acc.wr_data[0];
            type_q[acc.wr_index]     <= acc.wr_data[1];
         end
         if (acc.wr_stb && acc.wr_region == REG_CONFIG)
            reverse_q <= acc.wr_data[0];    // Bit 0 reverses priority order
      end
   end

   // Clear pulse lives for the cycle after the request
   always_comb begin
      cfg.gw_clear = '0;
      if (wr_src && acc.wr_region == REG_GW_CLEAR)
         cfg.gw_clear[acc.wr_index] = 1'b1;
   end

   assign cfg.src_prio      = prio_q;
   assign cfg.enable        = enable_q;
   assign cfg.gw_polarity   = polarity_q;
   assign cfg.gw_type       = type_q;
   assign cfg.reverse_order = reverse_q;

   ////////////////////////////////////////////////////////////////////////////
   // Read data
   always_comb begin
      rd_data = '0;
      if (acc.rd_stb) begin
         case (acc.rd_region)
            REG_PRIORITY:  rd_data = 32'(prio_q[acc.rd_index]);
            REG_PENDING:   if (acc.rd_index == '0) rd_data = 32'(pending);
            REG_ENABLE:    rd_data = 32'(enable_q[acc.rd_index]);
            REG_CONFIG:    rd_data = 32'(reverse_q);
            REG_GW_CONFIG: rd_data = {30'b0, type_q[acc.rd_index], polarity_q[acc.rd_index]};
            default:       rd_data = '0;   // Clear region and unmapped
         endcase
      end
   end

   assign picm_rd_data = acc.bypass ? acc.wr_data : rd_data;

endmodule

//--- design/pic_gateway.sv
// Interrupt source gateway

`timescale 1ns/1ps

module pic_gateway (
   input  logic clk,
   input  logic reset,
   input  logic req,          // Asynchronous request
   input  logic polarity,     // 1 means active low
   input  logic latch_type,   // 1 means latched edge
   input  logic clear,
   output logic active
);

   logic [1:0] sync_q;
   logic       req_lvl;
   logic       pend_q;

   // Two flop synchronizer
   always_ff @(posedge clk) begin
      if (reset) sync_q <= '0;
      else       sync_q <= {sync_q[0], req};
   end

   assign req_lvl = sync_q[1] ^ polarity;

   // Held until cleared, request wins over a same-cycle clear
   always_ff @(posedge clk) begin
      if (reset)
         pend_q <= 1'b0;
      else
         pend_q <= latch_type & (req_lvl | (pend_q & ~clear));
   end

   assign active = req_lvl | (latch_type & pend_q);

endmodule

//--- design/pic_priority_tree.sv
// Gateways and priority tree

`timescale 1ns/1ps

module pic_priority_tree import pic_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  src_vec_t   extintsrc_req,
   pic_cfg_if.sink    cfg,
   output src_vec_t   pending,
   output src_id_t    win_id,
   output prio_t      win_prio
);

   prio_t   [TREE_LEVELS:0][NUM_SOURCES-1:0] lvl_prio;
   src_id_t [TREE_LEVELS:0][NUM_SOURCES-1:0] lvl_id;

   for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_src
      if (i == 0) begin : g_reserved
         assign pending[i] = 1'b0;
      end else begin : g_gw
         pic_gateway gw_i (
            .clk        (clk),
            .reset      (reset),
            .req        (extintsrc_req[i]),
            .polarity   (cfg.gw_polarity[i]),
            .latch_type (cfg.gw_type[i]),
            .clear      (cfg.gw_clear[i]),
            .active     (pending[i])
         );
      end

      // Effective priority, zero when idle or masked
      assign lvl_prio[0][i] = (pending[i] & cfg.enable[i]) ?
                              (cfg.reverse_order ? ~cfg.src_prio[i] : cfg.src_prio[i]) : '0;
      assign lvl_id[0][i]   = src_id_t'(i);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare and select, ties keep the lower id
   for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_lvl
      for (genvar m = 0; m < NUM_SOURCES; m++) begin : g_cmp
         if (m < (NUM_SOURCES >> (l + 1))) begin : g_node
            logic b_wins;
            assign b_wins          = lvl_prio[l][2*m] < lvl_prio[l][2*m+1];
            assign lvl_prio[l+1][m] = b_wins ? lvl_prio[l][2*m+1] : lvl_prio[l][2*m];
            assign lvl_id[l+1][m]   = b_wins ? lvl_id[l][2*m+1]   : lvl_id[l][2*m];
         end else begin : g_pad
            assign lvl_prio[l+1][m] = '0;   // Past the end of this level
            assign lvl_id[l+1][m]   = '0;
         end
      end
   end

   assign win_id   = lvl_id[TREE_LEVELS][0];
   assign win_prio = lvl_prio[TREE_LEVELS][0];

endmodule

//--- design/pic_claim.sv
// Claim and threshold stage

`timescale 1ns/1ps

module pic_claim import pic_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  src_id_t   win_id,
   input  prio_t     win_prio,     // Effective, in tree order
   input  prio_t     meipt,
   input  prio_t     meicurpl,
   pic_cfg_if.sink   cfg,
   output src_id_t   claimid,
   output prio_t     pl,
   output logic      mexintpend,
   output logic      mhwakeup
);

   prio_t pl_d;
   prio_t meipt_eff;
   prio_t meicurpl_eff;
   prio_t top_lvl;
   logic  mexintpend_d;
   logic  mhwakeup_d;

   // Back to software order for reporting
   assign pl_d = cfg.reverse_order ? ~win_prio : win_prio;

   // Thresholds moved into tree order
   assign meipt_eff    = cfg.reverse_order ? ~meipt : meipt;
   assign meicurpl_eff = cfg.reverse_order ? ~meicurpl : meicurpl;
   assign mexintpend_d = (win_prio > meipt_eff) & (win_prio > meicurpl_eff);

   assign top_lvl    = cfg.reverse_order ? '0 : MAX_PRIO;
   assign mhwakeup_d = (pl_d == top_lvl);

   ////////////////////////////////////////////////////////////////////////////
   // Output registers
   always_ff @(posedge clk) begin
      if (reset) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= win_id;
         pl         <= pl_d;
         mexintpend <= mexintpend_d;
         mhwakeup   <= mhwakeup_d;
      end
   end

endmodule

//--- design/pic_ctrl.sv
// Interrupt controller top

`timescale 1ns/1ps

module pic_ctrl import pic_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  src_vec_t    extintsrc_req,   // Raw interrupt requests
   input  logic [31:0] picm_rdaddr,
   input  logic [31:0] picm_wraddr,
   input  logic [31:0] picm_wr_data,
   input  logic        picm_wren,
   input  logic        picm_rden,
   input  prio_t       meicurpl,        // Current priority level
   input  prio_t       meipt,           // Priority threshold
   output logic        mexintpend,
   output src_id_t     claimid,
   output prio_t       pl,
   output logic [31:0] picm_rd_data,
   output logic        mhwakeup
);

   src_vec_t pending;
   src_id_t  win_id;
   prio_t    win_prio;

   pic_access_if acc_if ();
   pic_cfg_if    cfg_if ();

   pic_access_decode decode_i (
      .clk          (clk),
      .reset        (reset),
      .picm_rdaddr  (picm_rdaddr),
      .picm_wraddr  (picm_wraddr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .acc          (acc_if.decode)
   );

   pic_reg_file regs_i (
      .clk          (clk),
      .reset        (reset),
      .acc          (acc_if.regs),
      .pending      (pending),
      .picm_rd_data (picm_rd_data),
      .cfg          (cfg_if.regs)
   );

   pic_priority_tree tree_i (
      .clk           (clk),
      .reset         (reset),
      .extintsrc_req (extintsrc_req),
      .cfg           (cfg_if.sink),
      .pending       (pending),
      .win_id        (win_id),
      .win_prio      (win_prio)
   );

   pic_claim claim_i (
      .clk        (clk),
      .reset      (reset),
      .win_id     (win_id),
      .win_prio   (win_prio),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .cfg        (cfg_if.sink),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

//--- verification/tb_pic_ctrl.sv
// Interrupt controller testbench

`timescale 1ns/1ps

module tb_pic_ctrl import pic_pkg::*; ();

   logic        clk, reset;
   src_vec_t    extintsrc_req;
   logic [31:0] picm_rdaddr, picm_wraddr, picm_wr_data, picm_rd_data;
   logic        picm_wren, picm_rden;
   prio_t       meicurpl, meipt, pl;
   src_id_t     claimid;
   logic        mexintpend, mhwakeup;

   // Shadow registers and latched gateway state
   prio_t    m_prio [NUM_SOURCES];
   src_vec_t m_en, m_pol, m_type, m_latch;
   logic     m_rev;
   src_id_t  exp_id;
   prio_t    exp_pl;
   logic     exp_int, exp_wake;

   pic_ctrl dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checking
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "wait timed out");
   endtask

   function automatic logic [31:0] reg_addr(input logic [31:0] offset, input int idx);
      return PIC_BASE_ADDR + offset + 32'(idx * 4);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus access, each task starts and ends on a falling edge
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      picm_wren    = 1'b1;
      picm_wraddr  = addr;
      picm_wr_data = data;
      @(negedge clk);
      picm_wren    = 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      picm_rden   = 1'b1;
      picm_rdaddr = addr;
      @(negedge clk);
      picm_rden   = 1'b0;
      data        = picm_rd_data;    // Valid the cycle after sampling
   endtask

   task automatic read_check(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
      logic [31:0] data;
      bus_read(addr, data);
      check_value(name, data, expected);
   endtask

   task automatic set_prio(input int i, input logic [31:0] d);
      bus_write(reg_addr(PRIORITY_OFFSET, i), d);
      if (i != 0) m_prio[i] = d[3:0];
   endtask

   task automatic set_enable(input int i, input logic [31:0] d);
      bus_write(reg_addr(ENABLE_OFFSET, i), d);
      if (i != 0) m_en[i] = d[0];
   endtask

   task automatic set_gw(input int i, input logic [31:0] d);
      bus_write(reg_addr(GW_CONFIG_OFFSET, i), d);
      if (i != 0) begin
         m_pol[i]  = d[0];
         m_type[i] = d[1];     // Latched edge
      end
   endtask

   task automatic set_config(input logic [31:0] d);
      bus_write(reg_addr(CONFIG_OFFSET, 0), d);
      m_rev = d[0];
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   task automatic update_latches();
      for (int i = 1; i < NUM_SOURCES; i++) begin
         if (!m_type[i])                          m_latch[i] = 1'b0;
         else if (extintsrc_req[i] ^ m_pol[i])    m_latch[i] = 1'b1;
      end
   endtask

   function automatic src_vec_t model_pending();
      src_vec_t p;
      p = '0;
      for (int i = 1; i < NUM_SOURCES; i++)
         p[i] = (extintsrc_req[i] ^ m_pol[i]) | (m_type[i] & m_latch[i]);
      return p;
   endfunction

   task automatic compute_expected();
      src_vec_t p;
      prio_t    best, eff, thr, cur;
      p      = model_pending();
      best   = '0;
      exp_id = '0;                    // Nothing above zero keeps source 0
      for (int i = 1; i < NUM_SOURCES; i++) begin
         eff = m_rev ? ~m_prio[i] : m_prio[i];
         if (p[i] && m_en[i] && eff > best) begin
            best   = eff;
            exp_id = src_id_t'(i);
         end
      end
      thr      = m_rev ? ~meipt : meipt;
      cur      = m_rev ? ~meicurpl : meicurpl;
      exp_pl   = m_rev ? ~best : best;
      exp_int  = (best > thr) && (best > cur);
      exp_wake = (exp_pl == (m_rev ? prio_t'(0) : prio_t'(15)));
   endtask

   // Wait for pending and then the claim to reach the model, then check all outputs
   task automatic settle_and_check();
      logic [31:0] rd;
      int          cycles;
      compute_expected();
      cycles = 0;
      bus_read(reg_addr(PENDING_OFFSET, 0), rd);
      while (rd !== model_pending()) begin
         if (cycles == 8) report_timeout("pending register never settled to the model");
         bus_read(reg_addr(PENDING_OFFSET, 0), rd);
         cycles++;
      end
      cycles = 0;
      while (claimid !== exp_id || pl !== exp_pl) begin
         if (cycles == 12) report_timeout("claimid and pl never settled to the model");
         @(negedge clk);
         cycles++;
      end
      check_value("mexintpend", mexintpend, exp_int);
      check_value("mhwakeup", mhwakeup, exp_wake);
   endtask

   task automatic random_round(input logic rev, input logic rand_pol);
      set_config({31'b0, rev});
      for (int i = 1; i < NUM_SOURCES; i++) begin
         set_gw(i, rand_pol ? 32'($urandom % 2) : 32'h0);
         set_prio(i, $urandom % 16);
         set_enable(i, $urandom % 2);
      end
      extintsrc_req = src_vec_t'($urandom);
      meipt         = prio_t'($urandom);
      meicurpl      = prio_t'($urandom);
      update_latches();
      settle_and_check();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      logic [31:0] d, rdata;
      int          r, s;
      void'($urandom(32'h3b92_d4c5));
      reset = 1'b1;
      extintsrc_req = '0;
      picm_rdaddr = '0;
      picm_wraddr = '0;
      picm_wr_data = '0;
      picm_wren = 1'b0;
      picm_rden = 1'b0;
      meicurpl = '0;
      meipt = '0;
      m_en = '0;
      m_pol = '0;
      m_type = '0;
      m_latch = '0;
      m_rev = 1'b0;
      for (int i = 0; i < NUM_SOURCES; i++) m_prio[i] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      settle_and_check();                       // Idle outputs after reset

      // Register readback
      for (int n = 0; n < 40; n++) begin
         r = $urandom % 4;
         s = $urandom % 32;
         d = $urandom;
         case (r)
            0: begin
               set_prio(s, d);
               read_check("priority", reg_addr(PRIORITY_OFFSET, s), 32'(m_prio[s]));
            end
            1: begin
               set_enable(s, d);
               read_check("enable", reg_addr(ENABLE_OFFSET, s), 32'(m_en[s]));
            end
            2: begin
               set_gw(s, d);
               read_check("gw_config", reg_addr(GW_CONFIG_OFFSET, s),
                          {30'b0, m_type[s], m_pol[s]});
            end
            default: begin
               set_config(d);
               read_check("config", reg_addr(CONFIG_OFFSET, 0), 32'(m_rev));
            end
         endcase
      end

      // Source 0 is reserved and ignores writes
      set_prio(0, 32'hF);
      read_check("priority", reg_addr(PRIORITY_OFFSET, 0), 32'h0);
      set_enable(0, 32'h1);
      read_check("enable", reg_addr(ENABLE_OFFSET, 0), 32'h0);
      set_gw(0, 32'h3);
      read_check("gw_config", reg_addr(GW_CONFIG_OFFSET, 0), 32'h0);

      read_check("unmapped", reg_addr(32'h0000_6000, 0), 32'h0);
      read_check("unmapped", reg_addr(CONFIG_OFFSET, 1), 32'h0);
      read_check("unmapped", reg_addr(PENDING_OFFSET, 1), 32'h0);
      read_check("unmapped", 32'h0000_0004, 32'h0);
      read_check("gw_clear", reg_addr(GW_CLEAR_OFFSET, 3), 32'h0);

      // Bypass of a same-cycle read and write
      s = 1 + $urandom % 31;
      d = $urandom;
      picm_rden = 1'b1;
      picm_rdaddr = reg_addr(PRIORITY_OFFSET, s);
      picm_wren = 1'b1;
      picm_wraddr = reg_addr(PRIORITY_OFFSET, s);
      picm_wr_data = d;
      @(negedge clk);
      picm_rden = 1'b0;
      picm_wren = 1'b0;
      rdata = picm_rd_data;
      check_value("bypass", rdata, d);
      m_prio[s] = d[3:0];

      // Level arbitration
      for (int n = 0; n < 6; n++) random_round(1'b0, 1'b0);

      // Latched edge, held until cleared
      s = 1 + $urandom % 31;
      extintsrc_req = '0;
      meipt = '0;
      meicurpl = '0;
      set_gw(s, 32'h2);
      set_prio(s, 15);
      set_enable(s, 1);
      update_latches();
      settle_and_check();
      extintsrc_req[s] = 1'b1;
      update_latches();
      repeat (2) @(negedge clk);
      extintsrc_req[s] = 1'b0;
      update_latches();
      settle_and_check();
      repeat (3) @(negedge clk);                // Pulse has left the synchronizer
      check_value("claimid", claimid, s);
      read_check("pending", reg_addr(PENDING_OFFSET, 0), model_pending());
      bus_write(reg_addr(GW_CLEAR_OFFSET, s), 32'h1);
      m_latch[s] = 1'b0;
      settle_and_check();

      // Polarity, then reverse order
      for (int n = 0; n < 3; n++) random_round(1'b0, 1'b1);
      for (int n = 0; n < 4; n++) random_round(1'b1, 1'b1);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- project.f
design/pic_pkg.sv
design/pic_access_if.sv
design/pic_cfg_if.sv
design/pic_access_decode.sv
design/pic_reg_file.sv
design/pic_gateway.sv
design/pic_priority_tree.sv
design/pic_claim.sv
design/pic_ctrl.sv
verification/tb_pic_ctrl.sv
